/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // Architectural sizes
    ////////////////////////////////////////
    localparam int NUM_ARCH_REGS = 8;                   // r0 is an ordinary register
    localparam int REG_IDX_W     = $clog2(NUM_ARCH_REGS);
    localparam int XLEN          = 32;                  // Data path width
    localparam int IMM_W         = 16;                  // Load-immediate field

    // Operation codes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,                                  // rs1 - rs2
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LI  = 3'd4                                   // rd = zero-extended imm
    } alu_op_e;

    // Decoded instruction, 28 bits
    typedef struct packed {
        alu_op_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [IMM_W-1:0]     imm;                      // Unused by reg-reg ops
    } instr_t;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    ////////////////////////////////////////
    // Reorder buffer sizing
    ////////////////////////////////////////
    localparam int ROB_DEPTH = 16;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);       // Tag is the entry number

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Operand word, holds either the value or the producer tag
    typedef union packed {
        logic [XLEN-1:0] data;                          // Meaningful when rdy is set
        struct packed {
            logic [XLEN-ROB_TAG_W-1:0] pad;             // Zero while waiting
            rob_tag_t                  tag;
        } t;
    } operand_u;

    typedef struct packed {
        logic     rdy;                                  // 1 value, 0 tag
        operand_u val;
    } operand_t;

    ////////////////////////////////////////
    // Bundles between stages
    ////////////////////////////////////////
    typedef struct packed {
        alu_op_e          op;
        operand_t         src1;
        operand_t         src2;
        logic [IMM_W-1:0] imm;
        rob_tag_t         tag;                          // Own reorder buffer slot
    } rs_entry_t;

    // Result bus
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;                       // Kept until commit
    } rob_alloc_t;

    typedef struct packed {
        rob_tag_t             tag;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
    } commit_t;

endpackage

`default_nettype wire

/* hw/dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire instr_t          in_instr,
    input  wire                  in_valid,
    output logic                 in_ready,
    output logic [REG_IDX_W-1:0] src1_reg,
    output logic [REG_IDX_W-1:0] src2_reg,
    input  wire operand_t        src1_lookup,       // Value or producer tag
    input  wire operand_t        src2_lookup,
    output rob_tag_t             rob_query1,
    output rob_tag_t             rob_query2,
    input  wire                  rob_done1,
    input  wire                  rob_done2,
    input  wire [XLEN-1:0]       rob_value1,
    input  wire [XLEN-1:0]       rob_value2,
    input  wire cdb_t            cdb,
    input  wire rob_tag_t        alloc_tag,
    input  wire                  rob_full,
    input  wire                  rs_has_free,
    output logic                 rs_write,
    output rs_entry_t            rs_entry,
    output logic                 rob_alloc,
    output rob_alloc_t           alloc
);

    logic accept;

    // Tag from the rename file becomes a value if its producer is done or on the bus now
    function automatic operand_t resolve(input operand_t lk, input logic done,
                                         input logic [XLEN-1:0] value, input cdb_t bus);
        operand_t res;
        res = lk;
        if (!lk.rdy) begin
            if (done) begin                             // Finished, waiting in ROB
                res.rdy      = 1'b1;
                res.val.data = value;
            end else if (bus.valid && bus.tag == lk.val.t.tag) begin
                res.rdy      = 1'b1;                    // Station would miss this broadcast
                res.val.data = bus.value;
            end
        end
        return res;
    endfunction

    assign src1_reg   = in_instr.rs1;
    assign src2_reg   = in_instr.rs2;
    assign rob_query1 = src1_lookup.val.t.tag;          // Don't care when register is free
    assign rob_query2 = src2_lookup.val.t.tag;

    assign in_ready  = rs_has_free && !rob_full;        // Room in both structures
    assign accept    = in_valid && in_ready;
    assign rs_write  = accept;
    assign rob_alloc = accept;
    assign alloc     = '{rd: in_instr.rd};

    always_comb begin
        rs_entry.op  = in_instr.op;
        rs_entry.imm = in_instr.imm;
        rs_entry.tag = alloc_tag;
        if (in_instr.op == OP_LI) begin                 // No register sources
            rs_entry.src1.rdy      = 1'b1;
            rs_entry.src1.val.data = '0;
            rs_entry.src2.rdy      = 1'b1;
            rs_entry.src2.val.data = '0;
        end else begin
            rs_entry.src1 = resolve(src1_lookup, rob_done1, rob_value1, cdb);
            rs_entry.src2 = resolve(src2_lookup, rob_done2, rob_value2, cdb);
        end
    end

endmodule

`default_nettype wire

/* hw/rename_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_regfile
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [REG_IDX_W-1:0]  rd1_idx,
    input  wire [REG_IDX_W-1:0]  rd2_idx,
    output operand_t             rd1_op,
    output operand_t             rd2_op,
    input  wire                  map_en,            // New producer for map_idx
    input  wire [REG_IDX_W-1:0]  map_idx,
    input  wire rob_tag_t        map_tag,
    input  wire                  commit_en,
    input  wire commit_t         commit_in
);

    logic [XLEN-1:0]          reg_val [NUM_ARCH_REGS];  // Committed values
    logic [NUM_ARCH_REGS-1:0] reg_busy;                 // Result still in flight
    rob_tag_t                 reg_tag [NUM_ARCH_REGS];  // Youngest producer

    // Busy register reads as its tag, free one as its value
    function automatic operand_t lookup(input logic [REG_IDX_W-1:0] idx);
        operand_t op;
        op.rdy = !reg_busy[idx];
        if (reg_busy[idx]) begin
            op.val.t.pad = '0;
            op.val.t.tag = reg_tag[idx];
        end else begin
            op.val.data = reg_val[idx];
        end
        return op;
    endfunction

    always_comb begin
        rd1_op = lookup(rd1_idx);
        rd2_op = lookup(rd2_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                reg_val[i] <= '0;
                reg_tag[i] <= '0;
            end
            reg_busy <= '0;
        end else begin
            if (commit_en) begin
                reg_val[commit_in.rd] <= commit_in.value;
                if (reg_tag[commit_in.rd] == commit_in.tag) begin
                    reg_busy[commit_in.rd] <= 1'b0;     // Youngest producer retired
                end
            end
            // Mapping comes last so it overrides a same-cycle clear
            if (map_en) begin
                reg_busy[map_idx] <= 1'b1;
                reg_tag[map_idx]  <= map_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            wr_en,
    input  wire rs_entry_t wr_entry,
    output logic           has_free,
    input  wire cdb_t      cdb,
    output logic           issue_valid,
    output rs_entry_t      issue_entry
);

    rs_entry_t  slot [2];                               // Entry payloads
    logic [1:0] occ;                                    // Slot occupied
    logic       old_idx;                                // Slot holding the older entry
    logic [1:0] rdy;                                    // Both operands present
    logic       wr_idx;
    logic       iss_idx;

    // Operand wakeup from the result bus
    function automatic operand_t snoop(input operand_t op, input cdb_t bus);
        operand_t res;
        res = op;
        if (!op.rdy && bus.valid && bus.tag == op.val.t.tag) begin
            res.rdy      = 1'b1;
            res.val.data = bus.value;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rdy[i] = occ[i] && slot[i].src1.rdy && slot[i].src2.rdy;
        end
    end

    ////////////////////////////////////////
    // Select, older first when both ready
    ////////////////////////////////////////
    assign iss_idx     = (rdy[0] && rdy[1]) ? old_idx : rdy[1];
    assign issue_valid = |rdy;
    assign issue_entry = slot[iss_idx];

    assign has_free = !(occ[0] && occ[1]);
    assign wr_idx   = occ[0];                           // Lowest free slot

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            slot[i].src1 <= snoop(slot[i].src1, cdb);
            slot[i].src2 <= snoop(slot[i].src2, cdb);
        end
        if (wr_en) begin
            slot[wr_idx] <= wr_entry;                   // Free slot, no wakeup race
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ     <= '0;
            old_idx <= 1'b0;
        end else begin
            if (issue_valid) begin
                occ[iss_idx] <= 1'b0;
            end
            if (wr_en) begin
                occ[wr_idx] <= 1'b1;
                old_idx     <= !wr_idx;                 // Other slot, if held, came first
            end
        end
    end

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            issue_valid,
    input  wire rs_entry_t issue_entry,
    output cdb_t           cdb
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            res_valid;                         // Bus valid, one cycle after issue
    rob_tag_t        res_tag;
    logic [XLEN-1:0] res_value;

    assign op_a = issue_entry.src1.val.data;            // Both ready at issue
    assign op_b = issue_entry.src2.val.data;

    always_comb begin
        case (issue_entry.op)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_LI:   result = {{(XLEN-IMM_W){1'b0}}, issue_entry.imm};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res_tag   <= issue_entry.tag;
            res_value <= result;
        end
    end

    assign cdb = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             alloc_en,
    input  wire rob_alloc_t alloc,
    output rob_tag_t        alloc_tag,
    output logic            full,
    input  wire rob_tag_t   query1,
    input  wire rob_tag_t   query2,
    output logic            done1,
    output logic            done2,
    output logic [XLEN-1:0] value1,
    output logic [XLEN-1:0] value2,
    input  wire cdb_t       cdb,
    output commit_t         commit,
    output logic            commit_valid,
    input  wire             commit_ready
);

    rob_tag_t             head;                         // Oldest entry
    rob_tag_t             tail;                         // Next slot to allocate
    logic [ROB_TAG_W:0]   count;                        // 0 to ROB_DEPTH
    logic [ROB_DEPTH-1:0] busy;                         // Allocated, not yet committed
    logic [ROB_DEPTH-1:0] fin;                          // Result written
    logic [REG_IDX_W-1:0] dest  [ROB_DEPTH];
    logic [XLEN-1:0]      value [ROB_DEPTH];
    logic                 commit_fire;

    assign alloc_tag = tail;
    assign full      = (count == (ROB_TAG_W+1)'(ROB_DEPTH));

    // Operand lookups from dispatch
    assign done1  = fin[query1];
    assign done2  = fin[query2];
    assign value1 = value[query1];
    assign value2 = value[query2];

    ////////////////////////////////////////
    // In-order commit
    ////////////////////////////////////////
    assign commit_valid = busy[head] && fin[head];
    assign commit_fire  = commit_valid && commit_ready; // Head holds while stalled
    assign commit       = '{tag: head, rd: dest[head], value: value[head]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            fin   <= '0;
        end else begin
            if (cdb.valid) begin
                fin[cdb.tag] <= 1'b1;                   // Keeps collecting under stall
            end
            if (commit_fire) begin
                busy[head] <= 1'b0;
                fin[head]  <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc_en) begin                         // Never the head slot, not full
                busy[tail] <= 1'b1;
                fin[tail]  <= 1'b0;
                tail       <= tail + 1'b1;
            end
            case ({alloc_en, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            dest[tail] <= alloc.rd;
        end
        if (cdb.valid) begin
            value[cdb.tag] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire instr_t in_instr,
    input  wire         in_valid,
    output logic        in_ready,
    output commit_t     commit,
    output logic        commit_valid,
    input  wire         commit_ready
);

    logic [REG_IDX_W-1:0] src1_reg, src2_reg;           // Rename file read indices
    operand_t             src1_lookup, src2_lookup;
    rob_tag_t             rob_query1, rob_query2;       // Producer lookups
    logic                 rob_done1, rob_done2;
    logic [XLEN-1:0]      rob_value1, rob_value2;
    rob_tag_t             alloc_tag;                    // Next free ROB slot
    logic                 rob_full;
    logic                 rs_has_free;
    logic                 rs_write;
    rs_entry_t            rs_entry;
    logic                 rob_alloc;
    rob_alloc_t           alloc;
    logic                 issue_valid;
    rs_entry_t            issue_entry;
    cdb_t                 cdb;                          // Watched by dispatch, station, ROB

    ////////////////////////////////////////
    // Front half, rename and dispatch
    ////////////////////////////////////////
    dispatch_unit i_dispatch (
        .in_instr, .in_valid, .in_ready,
        .src1_reg, .src2_reg, .src1_lookup, .src2_lookup,
        .rob_query1, .rob_query2, .rob_done1, .rob_done2, .rob_value1, .rob_value2,
        .cdb, .alloc_tag, .rob_full, .rs_has_free,
        .rs_write, .rs_entry, .rob_alloc, .alloc
    );

    rename_regfile i_rename (
        .clk, .rst_n,
        .rd1_idx   (src1_reg),
        .rd2_idx   (src2_reg),
        .rd1_op    (src1_lookup),
        .rd2_op    (src2_lookup),
        .map_en    (rob_alloc),                         // Every instruction writes rd
        .map_idx   (alloc.rd),
        .map_tag   (alloc_tag),
        .commit_en (commit_valid && commit_ready),      // Architectural write on transfer
        .commit_in (commit)
    );

    ////////////////////////////////////////
    // Back half, issue, execute, retire
    ////////////////////////////////////////
    reservation_station i_rs (
        .clk, .rst_n, .cdb, .issue_valid, .issue_entry,
        .wr_en    (rs_write),
        .wr_entry (rs_entry),
        .has_free (rs_has_free)
    );

    int_alu i_alu (.clk, .rst_n, .issue_valid, .issue_entry, .cdb);

    reorder_buffer i_rob (
        .clk, .rst_n, .alloc, .alloc_tag, .cdb, .commit, .commit_valid, .commit_ready,
        .alloc_en (rob_alloc),
        .full     (rob_full),
        .query1   (rob_query1),
        .query2   (rob_query2),
        .done1    (rob_done1),
        .done2    (rob_done2),
        .value1   (rob_value1),
        .value2   (rob_value2)
    );

endmodule

`default_nettype wire

/* bench/tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int NUM_ROWS       = 40;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 30 + 200;
    localparam int STALL_START    = 30;                 // Commit held off long enough to fill ROB
    localparam int STALL_END      = 80;

    // One program step with the value it must commit
    typedef struct packed {
        instr_t          instr;
        logic [XLEN-1:0] expect_val;
    } table_row_t;

    logic       clk;
    logic       rst_n;
    instr_t     in_instr;
    logic       in_valid;
    logic       in_ready;
    commit_t    commit;
    logic       commit_valid;
    logic       commit_ready;

    table_row_t  prog [NUM_ROWS];
    logic [31:0] lfsr_state;
    int          cycle;                                 // Edges since time zero
    int          accepted;                              // Dispatch transfers seen
    int          commit_count;                          // Commit transfers seen
    int          max_outstanding;

    ooo_core i_ooo_core (
        .clk, .rst_n, .in_instr, .in_valid, .in_ready,
        .commit, .commit_valid, .commit_ready
    );

    always #50 clk = ~clk;                              // 100 ns period

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("** Error %s: expected 0x%0h, actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    // Galois form for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic table_row_t make_row(input alu_op_e op, input int rd,
                                            input int rs1, input int rs2, input int imm);
        table_row_t r;
        r.instr.op   = op;
        r.instr.rd   = REG_IDX_W'(rd);
        r.instr.rs1  = REG_IDX_W'(rs1);
        r.instr.rs2  = REG_IDX_W'(rs2);
        r.instr.imm  = IMM_W'(imm);
        r.expect_val = '0;                              // Filled by the reference model
        return r;
    endfunction

    task automatic build_table();
        prog[0]  = make_row(OP_LI,  1, 0, 0, 'h0005);
        prog[1]  = make_row(OP_LI,  2, 0, 0, 'h0003);
        prog[2]  = make_row(OP_ADD, 3, 1, 2, 0);        // Both sources still in flight
        prog[3]  = make_row(OP_SUB, 4, 3, 1, 0);
        prog[4]  = make_row(OP_XOR, 5, 4, 3, 0);
        prog[5]  = make_row(OP_AND, 6, 5, 3, 0);
        prog[6]  = make_row(OP_ADD, 1, 1, 1, 0);        // Self chain
        prog[7]  = make_row(OP_ADD, 1, 1, 1, 0);
        prog[8]  = make_row(OP_ADD, 1, 1, 1, 0);
        prog[9]  = make_row(OP_ADD, 1, 1, 1, 0);
        prog[10] = make_row(OP_LI,  7, 0, 0, 'hffff);
        prog[11] = make_row(OP_ADD, 7, 7, 7, 0);
        prog[12] = make_row(OP_SUB, 0, 2, 7, 0);        // Wraps negative into the ordinary r0
        prog[13] = make_row(OP_XOR, 0, 0, 7, 0);
        prog[14] = make_row(OP_LI,  3, 0, 0, 'h0011);   // First of two writes to r3
        prog[15] = make_row(OP_LI,  3, 0, 0, 'h0022);
        prog[16] = make_row(OP_ADD, 4, 3, 3, 0);        // Must see the later r3
        prog[17] = make_row(OP_AND, 5, 7, 0, 0);
        prog[18] = make_row(OP_LI,  2, 0, 0, 'h1234);
        prog[19] = make_row(OP_ADD, 2, 2, 2, 0);
        prog[20] = make_row(OP_SUB, 6, 2, 4, 0);
        prog[21] = make_row(OP_XOR, 1, 1, 6, 0);
        prog[22] = make_row(OP_ADD, 0, 0, 0, 0);
        prog[23] = make_row(OP_LI,  4, 0, 0, 'ha5a5);
        prog[24] = make_row(OP_XOR, 4, 4, 2, 0);
        prog[25] = make_row(OP_ADD, 5, 4, 5, 0);
        prog[26] = make_row(OP_SUB, 5, 5, 1, 0);
        prog[27] = make_row(OP_AND, 7, 5, 4, 0);
        prog[28] = make_row(OP_LI,  6, 0, 0, 'h0001);
        prog[29] = make_row(OP_ADD, 6, 6, 6, 0);
        prog[30] = make_row(OP_ADD, 6, 6, 6, 0);
        prog[31] = make_row(OP_ADD, 6, 6, 6, 0);
        prog[32] = make_row(OP_SUB, 3, 6, 3, 0);
        prog[33] = make_row(OP_ADD, 3, 3, 7, 0);
        prog[34] = make_row(OP_XOR, 2, 3, 0, 0);
        prog[35] = make_row(OP_LI,  1, 0, 0, 'h7777);   // Overwritten before any read
        prog[36] = make_row(OP_LI,  1, 0, 0, 'h0101);
        prog[37] = make_row(OP_ADD, 0, 1, 2, 0);
        prog[38] = make_row(OP_SUB, 7, 0, 1, 0);
        prog[39] = make_row(OP_XOR, 4, 7, 3, 0);
    endtask

    // In-order reference model from all-zero registers
    task automatic compute_expected();
        logic [XLEN-1:0] regs [NUM_ARCH_REGS];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        for (int k = 0; k < NUM_ARCH_REGS; k++) begin
            regs[k] = '0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            a = regs[prog[i].instr.rs1];
            b = regs[prog[i].instr.rs2];
            case (prog[i].instr.op)
                OP_ADD:  r = a + b;
                OP_SUB:  r = a - b;
                OP_AND:  r = a & b;
                OP_XOR:  r = a ^ b;
                OP_LI:   r = {{(XLEN-IMM_W){1'b0}}, prog[i].instr.imm};
                default: r = '0;
            endcase
            prog[i].expect_val     = r;
            regs[prog[i].instr.rd] = r;
        end
    endtask

    ////////////////////////////////////////
    // Cycle count and timeout
    ////////////////////////////////////////
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf(
                "Timeout: only %0d of %0d rows committed after %0d cycles",
                commit_count, NUM_ROWS, cycle));
        end
    end

    // Commit back-pressure low about one cycle in four
    always @(posedge clk) begin
        logic b0;
        logic b1;
        if (!rst_n) begin
            commit_ready <= 1'b0;
        end else if (cycle >= STALL_START && cycle < STALL_END) begin
            commit_ready <= 1'b0;                       // Long stall window
        end else begin
            b0         = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            b1         = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            commit_ready <= !(b0 && b1);
        end
    end

    ////////////////////////////////////////
    // Transfer monitor and commit checks
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            if (accepted - commit_count == ROB_DEPTH) begin
                check_equal("in_ready_while_full", 0, 32'(in_ready));
            end
            if (in_valid && in_ready) begin
                accepted++;
            end
            if (commit_valid && commit_ready) begin
                if (commit_count >= NUM_ROWS) begin
                    stop_with_failure("A commit arrived after the last table row");
                end
                check_equal($sformatf("row%0d_tag", commit_count),
                            32'(commit_count % ROB_DEPTH), 32'(commit.tag));
                check_equal($sformatf("row%0d_rd", commit_count),
                            32'(prog[commit_count].instr.rd), 32'(commit.rd));
                check_equal($sformatf("row%0d_value", commit_count),
                            prog[commit_count].expect_val, commit.value);
                commit_count++;
            end
            if (accepted - commit_count > max_outstanding) begin
                max_outstanding = accepted - commit_count;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int idx;
        clk             = 1'b0;
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_instr        = '0;
        commit_ready    = 1'b0;
        lfsr_state      = 32'h22bc_905f;
        cycle           = 0;
        accepted        = 0;
        commit_count    = 0;
        max_outstanding = 0;
        build_table();
        compute_expected();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_equal("reset_in_ready", 1, 32'(in_ready));
        check_equal("reset_commit_valid", 0, 32'(commit_valid));

        // Table applied in order with each row held until accepted
        idx = 0;
        in_instr <= prog[0].instr;
        in_valid <= 1'b1;
        while (idx < NUM_ROWS) begin
            @(posedge clk);
            if (in_ready) begin                         // in_valid is high here
                idx++;
                if (idx < NUM_ROWS) begin
                    in_instr <= prog[idx].instr;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end

        while (commit_count < NUM_ROWS) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        check_equal("idle_commit_valid", 0, 32'(commit_valid));
        check_equal("rob_filled", ROB_DEPTH, 32'(max_outstanding));

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_core.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/dispatch_unit.sv
hw/rename_regfile.sv
hw/reservation_station.sv
hw/int_alu.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
bench/tb_ooo_core.sv

/* Makefile */
# Verilator flow for the out-of-order core back end

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
RTL_TOP   ?= ooo_core
FILELIST  ?= ooo_core.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing
PASS_MSG  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
